// ==== files.f ====
+incdir+include
source/soc_pkg.sv
source/bus_decoder.sv
source/boot_rom.sv
source/sram_target.sv
source/clint_timer.sv
source/debug_gate.sv
source/soc_harness.sv
verification/soc_harness_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the soc_harness testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Could not create $BUILD_DIR"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module soc_harness_tb -Mdir "$BUILD_DIR/obj_dir" -o soc_harness_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$BUILD_DIR/obj_dir/soc_harness_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== source/boot_rom.sv ====
/* Read-only table of ROM_WORDS words, indexed modulo its size. Writes get err and change nothing */
`timescale 1ns/1ns

module boot_rom (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  soc_pkg::bus_req_t req_data_i,
  output logic              ack_o,
  output soc_pkg::bus_rsp_t rsp_o
);
  import soc_pkg::*;

  logic                     ack_q;
  bus_rsp_t                 rsp_q;
  logic [ROM_IDX_WIDTH-1:0] idx;
  logic [DATA_WIDTH-1:0]    rom_word;

  assign idx = req_data_i.addr.word.index[ROM_IDX_WIDTH-1:0];

  // Tag, zero byte, then the word index
  assign rom_word = {ROM_TAG, 8'h00, {(8 - ROM_IDX_WIDTH){1'b0}}, idx};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_i;
    end
  end

  // Response captured once per transaction
  always_ff @(posedge clk_i) begin
    if (req_i && !ack_q) begin
      if (req_data_i.we) begin
        rsp_q.rdata <= '0;
        rsp_q.err   <= 1'b1;
      end else begin
        rsp_q.rdata <= rom_word;
        rsp_q.err   <= 1'b0;
      end
    end
  end

  assign ack_o = ack_q;
  assign rsp_o = rsp_q;

endmodule

// ==== source/bus_decoder.sv ====
/* One transaction at a time on a four-phase req/ack bus. GPIO and unmapped regions
   are answered by the built-in error target with err set and rdata zero. */
`timescale 1ns/1ns

module bus_decoder (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_i,
  input  soc_pkg::bus_req_t req_data_i,
  output logic             ack_o,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic             rom_req_o,
  output logic             clint_req_o,
  output logic             sram_req_o,
  output soc_pkg::bus_req_t tgt_data_o,
  input  logic             rom_ack_i,
  input  logic             clint_ack_i,
  input  logic             sram_ack_i,
  input  soc_pkg::bus_rsp_t rom_rsp_i,
  input  soc_pkg::bus_rsp_t clint_rsp_i,
  input  soc_pkg::bus_rsp_t sram_rsp_i
);
  import soc_pkg::*;

  logic [NUM_TGT-1:0] sel_q;
  logic [NUM_TGT-1:0] dec_sel;
  logic [NUM_TGT-1:0] tgt_ack;
  logic               tgt_req_q;
  logic               err_ack_q;
  logic               busy;
  logic               done;
  logic               accept;
  bus_req_t           tgt_data_q;

  always_comb begin
    dec_sel = '0;
    case (req_data_i.addr.map.region)
      REGION_ROM:   dec_sel[TGT_ROM] = 1'b1;
      REGION_CLINT: dec_sel[TGT_CLINT] = 1'b1;
      REGION_DRAM:  dec_sel[TGT_SRAM] = 1'b1;
      // GPIO and unmapped
      default:      dec_sel[TGT_ERR] = 1'b1;
    endcase
  end

  assign tgt_ack[TGT_ROM]   = rom_ack_i;
  assign tgt_ack[TGT_CLINT] = clint_ack_i;
  assign tgt_ack[TGT_SRAM]  = sram_ack_i;
  assign tgt_ack[TGT_ERR]   = err_ack_q;

  // Done once the target has seen req low and dropped its ack
  assign busy   = |sel_q;
  assign done   = busy && !tgt_req_q && !(|(sel_q & tgt_ack));
  assign accept = req_i && (!busy || done);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q     <= '0;
      tgt_req_q <= 1'b0;
      err_ack_q <= 1'b0;
    end else begin
      err_ack_q <= tgt_req_q && sel_q[TGT_ERR];
      if (accept) begin
        sel_q     <= dec_sel;
        tgt_req_q <= 1'b1;
      end else if (done) begin
        sel_q     <= '0;
        tgt_req_q <= 1'b0;
      end else if (busy) begin
        tgt_req_q <= req_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      tgt_data_q <= req_data_i;
    end
  end

  assign tgt_data_o  = tgt_data_q;
  assign rom_req_o   = tgt_req_q && sel_q[TGT_ROM];
  assign clint_req_o = tgt_req_q && sel_q[TGT_CLINT];
  assign sram_req_o  = tgt_req_q && sel_q[TGT_SRAM];

  assign ack_o = |(sel_q & tgt_ack);

  always_comb begin
    rsp_o = '0;
    if (sel_q[TGT_ROM]) begin
      rsp_o = rom_rsp_i;
    end else if (sel_q[TGT_CLINT]) begin
      rsp_o = clint_rsp_i;
    end else if (sel_q[TGT_SRAM]) begin
      rsp_o = sram_rsp_i;
    end else if (sel_q[TGT_ERR]) begin
      rsp_o.err = 1'b1;
    end
  end

  a_sel_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(sel_q));

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_o && $past(ack_o)) |-> $stable(rsp_o));

endmodule

// ==== source/clint_timer.sv ====
/* 32-bit mtime stepped by rising edges of rtc_i, which must be slower than half of clk_i.
   Only mtime and mtimecmp exist; other word offsets answer with err. */
`timescale 1ns/1ns

module clint_timer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rtc_i,
  input  logic              req_i,
  input  soc_pkg::bus_req_t req_data_i,
  output logic              ack_o,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic              timer_irq_o
);
  import soc_pkg::*;

  logic [2:0]                   rtc_sync_q;
  logic                         rtc_tick;
  logic [DATA_WIDTH-1:0]        mtime_q;
  logic [DATA_WIDTH-1:0]        mtimecmp_q;
  logic                         ack_q;
  logic                         irq_q;
  logic                         accept;
  logic                         hit_mtime;
  logic                         hit_cmp;
  logic [REGION_WORD_WIDTH-1:0] ofs;
  bus_rsp_t                     rsp_q;

  // Two stages of synchronizer, third stage for edge detect
  assign rtc_tick = rtc_sync_q[1] && !rtc_sync_q[2];

  assign ofs       = req_data_i.addr.word.index[REGION_WORD_WIDTH-1:0];
  assign hit_mtime = (ofs == REGION_WORD_WIDTH'(CLINT_MTIME_OFS));
  assign hit_cmp   = (ofs == REGION_WORD_WIDTH'(CLINT_MTIMECMP_OFS));
  assign accept    = req_i && !ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q <= '0;
      ack_q      <= 1'b0;
      irq_q      <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      rtc_sync_q <= {rtc_sync_q[1:0], rtc_i};
      ack_q      <= req_i;
      irq_q      <= (mtime_q >= mtimecmp_q);
      // A bus write wins over a tick in the same cycle
      if (accept && req_data_i.we && hit_mtime) begin
        mtime_q <= req_data_i.wdata;
      end else if (rtc_tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (accept && req_data_i.we && hit_cmp) begin
        mtimecmp_q <= req_data_i.wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.err <= !(hit_mtime || hit_cmp);
      if (req_data_i.we) begin
        rsp_q.rdata <= '0;
      end else if (hit_mtime) begin
        rsp_q.rdata <= mtime_q;
      end else if (hit_cmp) begin
        rsp_q.rdata <= mtimecmp_q;
      end else begin
        rsp_q.rdata <= '0;
      end
    end
  end

  assign ack_o       = ack_q;
  assign rsp_o       = rsp_q;
  assign timer_irq_o = irq_q;

  a_irq_off_when_cmp_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mtimecmp_q == '1 && mtime_q < mtimecmp_q) |=> !timer_irq_o);

endmodule

// ==== source/debug_gate.sv ====
/* Blocks debug requests for DEBUG_DELAY_CYCLES cycles after reset and while debug is disabled */
`timescale 1ns/1ns

module debug_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);
  import soc_pkg::*;

  logic [DEBUG_CNT_WIDTH-1:0] cnt_q;
  logic                       window_open;

  assign window_open = (cnt_q == '0);

  // Counts down once after reset and parks at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= DEBUG_CNT_WIDTH'(DEBUG_DELAY_CYCLES);
    end else if (!window_open) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = window_open && debug_req_i && debug_enable_i;

  a_blocked_in_window: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cnt_q != '0) |-> !debug_req_o);

endmodule

// ==== source/soc_harness.sv ====
/* Memory and peripheral side of a single-hart SoC, reached by one four-phase bus master */
`timescale 1ns/1ns

module soc_harness (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rtc_i,
  input  logic              req_i,
  input  soc_pkg::bus_req_t req_data_i,
  input  logic              debug_req_i,
  input  logic              debug_enable_i,
  output logic              ack_o,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic              timer_irq_o,
  output logic              debug_req_o
);
  import soc_pkg::*;

  logic     rom_req;
  logic     clint_req;
  logic     sram_req;
  logic     rom_ack;
  logic     clint_ack;
  logic     sram_ack;
  bus_req_t tgt_data;
  bus_rsp_t rom_rsp;
  bus_rsp_t clint_rsp;
  bus_rsp_t sram_rsp;

  bus_decoder i_bus_decoder (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .req_i       ( req_i      ),
    .req_data_i  ( req_data_i ),
    .ack_o       ( ack_o      ),
    .rsp_o       ( rsp_o      ),
    .rom_req_o   ( rom_req    ),
    .clint_req_o ( clint_req  ),
    .sram_req_o  ( sram_req   ),
    .tgt_data_o  ( tgt_data   ),
    .rom_ack_i   ( rom_ack    ),
    .clint_ack_i ( clint_ack  ),
    .sram_ack_i  ( sram_ack   ),
    .rom_rsp_i   ( rom_rsp    ),
    .clint_rsp_i ( clint_rsp  ),
    .sram_rsp_i  ( sram_rsp   )
  );

  boot_rom i_boot_rom (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .req_i      ( rom_req  ),
    .req_data_i ( tgt_data ),
    .ack_o      ( rom_ack  ),
    .rsp_o      ( rom_rsp  )
  );

  sram_target i_sram_target (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .req_i      ( sram_req ),
    .req_data_i ( tgt_data ),
    .ack_o      ( sram_ack ),
    .rsp_o      ( sram_rsp )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .req_data_i  ( tgt_data    ),
    .ack_o       ( clint_ack   ),
    .rsp_o       ( clint_rsp   ),
    .timer_irq_o ( timer_irq_o )
  );

  debug_gate i_debug_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

// ==== source/soc_pkg.sv ====
/* Address map, bus types and timing constants shared by the harness and its testbench.
   Regions decode on the top address nibble only; every target aliases inside its region. */
package soc_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  // Word index bits inside one region
  localparam int unsigned REGION_WORD_WIDTH = ADDR_WIDTH - 6;

  // ------------------------------
  // Targets
  // ------------------------------
  localparam int unsigned ROM_WORDS      = 16;
  localparam int unsigned ROM_IDX_WIDTH  = $clog2(ROM_WORDS);
  localparam logic [15:0] ROM_TAG        = 16'hB007;
  localparam int unsigned SRAM_WORDS     = 256;
  localparam int unsigned SRAM_IDX_WIDTH = $clog2(SRAM_WORDS);

  localparam int unsigned CLINT_MTIME_OFS    = 0;
  localparam int unsigned CLINT_MTIMECMP_OFS = 1;

  localparam int unsigned DEBUG_DELAY_CYCLES = 20;
  localparam int unsigned DEBUG_CNT_WIDTH    = $clog2(DEBUG_DELAY_CYCLES + 1);

  // One-hot select positions in the decoder
  localparam int unsigned NUM_TGT   = 4;
  localparam int unsigned TGT_ROM   = 0;
  localparam int unsigned TGT_CLINT = 1;
  localparam int unsigned TGT_SRAM  = 2;
  localparam int unsigned TGT_ERR   = 3;

  typedef enum logic [3:0] {
    REGION_ROM   = 4'h0,
    REGION_CLINT = 4'h1,
    REGION_GPIO  = 4'h2,
    REGION_DRAM  = 4'h8
  } region_e;

  typedef struct packed {
    region_e               region;
    logic [ADDR_WIDTH-5:0] offset;
  } soc_addr_map_t;

  typedef struct packed {
    logic [ADDR_WIDTH-3:0] index;
    logic [1:0]            byte_ofs;
  } soc_addr_word_t;

  // Decoder reads the map view, targets the word view
  typedef union packed {
    soc_addr_map_t  map;
    soc_addr_word_t word;
  } soc_addr_u;

  typedef struct packed {
    logic                  we;
    soc_addr_u             addr;
    logic [BE_WIDTH-1:0]   be;
    logic [DATA_WIDTH-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;
  } bus_rsp_t;

endpackage

// ==== source/sram_target.sv ====
/* SRAM_WORDS words with byte-enabled writes; the index wraps modulo the size.
   Contents are undefined after power-up. */
`timescale 1ns/1ns

module sram_target (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  soc_pkg::bus_req_t req_data_i,
  output logic              ack_o,
  output soc_pkg::bus_rsp_t rsp_o
);
  import soc_pkg::*;

  logic [DATA_WIDTH-1:0]     mem_q [SRAM_WORDS];
  logic [SRAM_IDX_WIDTH-1:0] idx;
  logic                      ack_q;
  logic                      accept;
  bus_rsp_t                  rsp_q;

  assign idx    = req_data_i.addr.word.index[SRAM_IDX_WIDTH-1:0];
  assign accept = req_i && !ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_i;
    end
  end

  // ------------------------------
  // Storage and read port
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (accept && req_data_i.we) begin
      for (int b = 0; b < BE_WIDTH; b++) begin
        if (req_data_i.be[b]) begin
          mem_q[idx][8*b +: 8] <= req_data_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.rdata <= req_data_i.we ? '0 : mem_q[idx];
      rsp_q.err   <= 1'b0;
    end
  end

  assign ack_o = ack_q;
  assign rsp_o = rsp_q;

  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ack_o) |-> req_i);

endmodule

// ==== include/tb_bus_tasks.svh ====
/* Needs soc_pkg imported and clk, req, req_data, ack, rsp declared in the including module.
   Inputs change on the falling edge of clk. */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// One four-phase transaction, req held for extra cycles after ack
task automatic bus_xfer(input logic we, input logic [ADDR_WIDTH-1:0] addr,
                        input logic [BE_WIDTH-1:0] be, input logic [DATA_WIDTH-1:0] wdata,
                        input int unsigned hold, output bus_rsp_t result);
  @(negedge clk);
  req_data.we    = we;
  req_data.addr  = addr;
  req_data.be    = be;
  req_data.wdata = wdata;
  req            = 1'b1;
  while (!ack) @(negedge clk);
  result = rsp;
  repeat (hold) @(negedge clk);
  req = 1'b0;
  while (ack) @(negedge clk);
endtask

task automatic bus_read(input logic [ADDR_WIDTH-1:0] addr, input int unsigned hold,
                        output bus_rsp_t result);
  bus_xfer(1'b0, addr, '0, '0, hold, result);
endtask

task automatic bus_write(input logic [ADDR_WIDTH-1:0] addr, input logic [BE_WIDTH-1:0] be,
                         input logic [DATA_WIDTH-1:0] wdata, input int unsigned hold,
                         output bus_rsp_t result);
  bus_xfer(1'b1, addr, be, wdata, hold, result);
endtask

// Expected ROM word for any index
function automatic logic [DATA_WIDTH-1:0] rom_model(input int unsigned idx);
  return {ROM_TAG, 8'h00, 8'(idx % ROM_WORDS)};
endfunction

// Byte merge as the SRAM applies it
function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
    input logic [DATA_WIDTH-1:0] new_word, input logic [BE_WIDTH-1:0] be);
  logic [DATA_WIDTH-1:0] res;
  res = old_word;
  for (int b = 0; b < BE_WIDTH; b++) begin
    if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];
  end
  return res;
endfunction

`endif

// ==== verification/soc_harness_tb.sv ====
/* Single bus master for soc_harness. Inputs change on the falling clock edge.
   Handshake timing and the debug window are checked by concurrent assertions. */
`timescale 1ns/1ns

module soc_harness_tb;
  import soc_pkg::*;

  localparam int unsigned CLK_PERIOD      = 100;
  localparam int unsigned ROM_XFERS       = 22;
  localparam int unsigned SRAM_BASES      = 8;
  localparam int unsigned SRAM_MERGES     = 16;
  localparam int unsigned SRAM_XFERS      = 2 * SRAM_BASES + SRAM_MERGES;
  localparam int unsigned ERR_XFERS       = 4;
  localparam int unsigned RTC_PULSES      = 6;
  localparam int unsigned TIMER_XFERS     = RTC_PULSES + 5;
  localparam int unsigned RTC_TOGGLES     = 2 * RTC_PULSES;
  localparam int unsigned TOTAL_XFERS     = ROM_XFERS + SRAM_XFERS + ERR_XFERS + TIMER_XFERS;
  localparam int unsigned WATCHDOG_CYCLES = TOTAL_XFERS * 10 + RTC_TOGGLES * 8 + 200;

  logic     clk;
  logic     rst_n;
  logic     rtc;
  logic     req;
  bus_req_t req_data;
  logic     debug_req;
  logic     debug_enable;
  logic     ack;
  bus_rsp_t rsp;
  logic     timer_irq;
  logic     debug_req_out;
  int       fail_count = 0;
  int       check_count = 0;
  int       test_fails = 0;
  int       test_checks = 0;
  int       edges_since_rst;
  integer   seed;
  logic [DATA_WIDTH-1:0] model_mem [SRAM_WORDS];

  `include "tb_bus_tasks.svh"

  soc_harness dut0 (
    .clk_i          ( clk           ),
    .rst_ni         ( rst_n         ),
    .rtc_i          ( rtc           ),
    .req_i          ( req           ),
    .req_data_i     ( req_data      ),
    .debug_req_i    ( debug_req     ),
    .debug_enable_i ( debug_enable  ),
    .ack_o          ( ack           ),
    .rsp_o          ( rsp           ),
    .timer_irq_o    ( timer_irq     ),
    .debug_req_o    ( debug_req_out )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      edges_since_rst <= 0;
    end else if (edges_since_rst < 1000) begin
      edges_since_rst <= edges_since_rst + 1;
    end
  end

  function automatic void note_failure(input string msg);
    fail_count++;
    $display("%s", msg);
  endfunction

  // ------------------------------
  // Handshake and debug window
  // ------------------------------
  a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(req) |-> ##2 $rose(ack))
    else note_failure("ack_o did not rise 2 cycles after req_i");
  a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(req) |-> ##2 $fell(ack))
    else note_failure("ack_o did not fall 2 cycles after req_i dropped");
  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (ack && $past(ack)) |-> $stable(rsp))
    else note_failure("rsp_o changed while ack_o was high");
  a_back_pressure: assert property (@(posedge clk) disable iff (!rst_n)
    (ack && req) |=> ack)
    else note_failure("ack_o dropped while req_i was still high");
  a_dbg_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    (edges_since_rst < DEBUG_DELAY_CYCLES) |-> !debug_req_out)
    else note_failure("debug_req_o was high inside the post-reset window");
  a_dbg_open: assert property (@(posedge clk) disable iff (!rst_n)
    (edges_since_rst >= DEBUG_DELAY_CYCLES && debug_req && debug_enable) |-> debug_req_out)
    else note_failure("debug_req_o stayed low after the post-reset window");
  a_dbg_disabled: assert property (@(posedge clk) disable iff (!rst_n)
    !debug_enable |-> !debug_req_out)
    else note_failure("debug_req_o was high with debug disabled");

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      fail_count++;
      $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("%-8s done: %0d checks, %0d failures", name, check_count - test_checks,
             fail_count - test_fails);
    test_checks = check_count;
    test_fails  = fail_count;
  endtask

  function automatic logic [ADDR_WIDTH-1:0] region_addr(input region_e region,
                                                        input int unsigned idx);
    return {region, (ADDR_WIDTH - 4)'(idx * 4)};
  endfunction

  task automatic pulse_rtc();
    @(negedge clk);
    rtc = 1'b1;
    repeat (4) @(negedge clk);
    rtc = 1'b0;
    repeat (4) @(negedge clk);
  endtask

  task automatic stop_with_failure();
    $display("Checks failed");
    $finish;
  endtask

  task automatic run_debug_test();
    for (int j = 0; j < DEBUG_DELAY_CYCLES; j++) begin
      check_eq("debug_req_o", debug_req_out, 1'b0);
      @(negedge clk);
    end
    check_eq("debug_req_o", debug_req_out, 1'b1);
    debug_enable = 1'b0;
    #1;
    check_eq("debug_req_o", debug_req_out, 1'b0);
    end_test("debug");
  endtask

  task automatic run_rom_test();
    bus_rsp_t r;
    for (int i = 0; i < 20; i++) begin
      bus_read(region_addr(REGION_ROM, i), i % 4, r);
      check_eq("rsp_o.rdata", r.rdata, rom_model(i));
      check_eq("rsp_o.err", r.err, 1'b0);
    end
    bus_write(region_addr(REGION_ROM, 3), 4'hF, 32'hDEAD_BEEF, 2, r);
    check_eq("rsp_o.err", r.err, 1'b1);
    bus_read(region_addr(REGION_ROM, 3), 0, r);
    check_eq("rsp_o.rdata", r.rdata, rom_model(3));
    end_test("rom");
  endtask

  task automatic run_sram_test();
    bus_rsp_t              r;
    int unsigned           bases [SRAM_BASES];
    int unsigned           idx;
    int unsigned           alias_idx;
    logic [DATA_WIDTH-1:0] data;
    logic [BE_WIDTH-1:0]   be;
    // Full words first so every merged byte is known
    for (int i = 0; i < SRAM_BASES; i++) begin
      bases[i]  = $unsigned($random(seed)) % SRAM_WORDS;
      alias_idx = bases[i] + SRAM_WORDS * ($unsigned($random(seed)) % 4);
      data      = $random(seed);
      bus_write(region_addr(REGION_DRAM, alias_idx), 4'hF, data, i % 3, r);
      model_mem[alias_idx % SRAM_WORDS] = data;
    end
    for (int i = 0; i < SRAM_MERGES; i++) begin
      alias_idx = bases[$unsigned($random(seed)) % SRAM_BASES]
                  + SRAM_WORDS * ($unsigned($random(seed)) % 4);
      idx       = alias_idx % SRAM_WORDS;
      data      = $random(seed);
      be        = BE_WIDTH'($random(seed));
      bus_write(region_addr(REGION_DRAM, alias_idx), be, data, i % 4, r);
      check_eq("rsp_o.rdata", r.rdata, '0);
      check_eq("rsp_o.err", r.err, 1'b0);
      model_mem[idx] = merge_bytes(model_mem[idx], data, be);
    end
    for (int i = 0; i < SRAM_BASES; i++) begin
      alias_idx = bases[i] + SRAM_WORDS * ($unsigned($random(seed)) % 4);
      bus_read(region_addr(REGION_DRAM, alias_idx), i % 3, r);
      check_eq("rsp_o.rdata", r.rdata, model_mem[bases[i]]);
      check_eq("rsp_o.err", r.err, 1'b0);
    end
    end_test("sram");
  endtask

  task automatic run_error_test();
    bus_rsp_t r;
    bus_read(region_addr(REGION_GPIO, 4), 1, r);
    check_eq("rsp_o.err", r.err, 1'b1);
    check_eq("rsp_o.rdata", r.rdata, '0);
    bus_write(region_addr(REGION_GPIO, 4), 4'hF, 32'h1234_5678, 0, r);
    check_eq("rsp_o.err", r.err, 1'b1);
    check_eq("rsp_o.rdata", r.rdata, '0);
    bus_read(32'h5000_0040, 2, r);
    check_eq("rsp_o.err", r.err, 1'b1);
    check_eq("rsp_o.rdata", r.rdata, '0);
    bus_write(32'h5000_0040, 4'h3, 32'hCAFE_F00D, 3, r);
    check_eq("rsp_o.err", r.err, 1'b1);
    check_eq("rsp_o.rdata", r.rdata, '0);
    end_test("error");
  endtask

  task automatic run_timer_test();
    bus_rsp_t r;
    bus_write(region_addr(REGION_CLINT, CLINT_MTIME_OFS), 4'hF, 32'd0, 1, r);
    check_eq("rsp_o.err", r.err, 1'b0);
    bus_write(region_addr(REGION_CLINT, CLINT_MTIMECMP_OFS), 4'hF, 32'd5, 0, r);
    check_eq("rsp_o.err", r.err, 1'b0);
    check_eq("timer_irq_o", timer_irq, 1'b0);
    for (int n = 1; n <= RTC_PULSES; n++) begin
      pulse_rtc();
      bus_read(region_addr(REGION_CLINT, CLINT_MTIME_OFS), n % 3, r);
      check_eq("mtime", r.rdata, n);
      check_eq("timer_irq_o", timer_irq, n >= 5);
    end
    // All ones compare value clears the interrupt again
    bus_write(region_addr(REGION_CLINT, CLINT_MTIMECMP_OFS), 4'hF, '1, 1, r);
    bus_read(region_addr(REGION_CLINT, CLINT_MTIMECMP_OFS), 0, r);
    check_eq("mtimecmp", r.rdata, 32'hFFFF_FFFF);
    check_eq("timer_irq_o", timer_irq, 1'b0);
    bus_read(region_addr(REGION_CLINT, 2), 0, r);
    check_eq("rsp_o.err", r.err, 1'b1);
    end_test("timer");
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    stop_with_failure();
  end

  initial begin
    seed         = 64459;
    rst_n        = 1'b0;
    rtc          = 1'b0;
    req          = 1'b0;
    req_data     = '0;
    debug_req    = 1'b1;
    debug_enable = 1'b1;
    repeat (5) @(negedge clk);
    check_eq("ack_o", ack, 1'b0);
    check_eq("timer_irq_o", timer_irq, 1'b0);
    check_eq("debug_req_o", debug_req_out, 1'b0);
    end_test("reset");
    rst_n = 1'b1;
    run_debug_test();
    run_rom_test();
    run_sram_test();
    run_error_test();
    run_timer_test();
    $display("Totals: %0d checks, %0d failures", check_count, fail_count);
    if (fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

endmodule
